//--- source/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// Datapath width and register file size
	localparam int WORD_W = 32;
	localparam int NUM_REGS = 8;

	// Bits needed to address the general registers
	localparam int REG_ADDR_W = $clog2(NUM_REGS);

	typedef logic [WORD_W-1:0] word_t;

	// Register fields are 4 bits wide in the encoding, only R0-R7 exist here
	typedef logic [3:0] reg_idx_t;

	// Numbering follows the original instruction set
	typedef enum logic [4:0] {
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_shr  = 5'd5,
		op_shra = 5'd6,
		op_shl  = 5'd7,
		op_ror  = 5'd8,
		op_rol  = 5'd9,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_neg  = 5'd17,
		op_not  = 5'd18
	} opcode_t;

	// Register-format instruction, opcode in bits 31:27
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rc;
		logic [14:0] unused;
	} instr_t;

endpackage

//--- source/datapath_ctrl_pkg.sv
package datapath_ctrl_pkg;

	// Commands accepted over the req/ack handshake
	typedef enum logic [1:0] {
		cmd_load    = 2'd0,
		cmd_execute = 2'd1,
		cmd_read    = 2'd2
	} cmd_kind_t;

	// For execute, data holds the instruction word
	typedef struct packed {
		cmd_kind_t kind;
		cpu_isa_pkg::reg_idx_t target;
		cpu_isa_pkg::word_t data;
	} cmd_t;

	// Who drives the shared bus
	typedef enum logic [1:0] {
		src_none = 2'd0,
		src_mdr  = 2'd1,
		src_z    = 2'd2,
		src_gpr  = 2'd3
	} bus_src_t;

	typedef struct packed {
		logic mdr_load;
		logic mdr_from_bus;
		bus_src_t bus_src;
		cpu_isa_pkg::reg_idx_t bus_reg;
		logic gpr_load;
		cpu_isa_pkg::reg_idx_t gpr_sel;
		logic ir_load;
		logic y_load;
		logic z_load;
	} ctrl_t;

	// One state per control step
	typedef enum logic [3:0] {
		st_idle, st_mdr_in, st_reg_in, st_ir_in, st_y_in,
		st_z_in, st_wb, st_mdr_out, st_done
	} step_t;

endpackage

//--- source/gp_register.sv
module gp_register #(
	parameter type payload_t = cpu_isa_pkg::word_t
) (
	input logic clk,
	input logic arst_n,
	input logic load,
	input payload_t d,
	output payload_t q
);

	// Holds until the next enabled edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (load) begin
			q <= d;
		end
	end

endmodule

//--- source/bus_mux.sv
module bus_mux (
	input datapath_ctrl_pkg::bus_src_t bus_src,
	input cpu_isa_pkg::reg_idx_t bus_reg,
	input cpu_isa_pkg::word_t mdr,
	input cpu_isa_pkg::word_t z,
	input cpu_isa_pkg::word_t gpr [cpu_isa_pkg::NUM_REGS],
	output cpu_isa_pkg::word_t bus
);

	logic reg_valid;

	// Register numbers past R7 read as zero
	assign reg_valid = (bus_reg < cpu_isa_pkg::reg_idx_t'(cpu_isa_pkg::NUM_REGS));

	always_comb begin
		case (bus_src)
			datapath_ctrl_pkg::src_mdr: bus = mdr;
			datapath_ctrl_pkg::src_z: bus = z;
			datapath_ctrl_pkg::src_gpr: begin
				if (reg_valid)
					bus = gpr[bus_reg[cpu_isa_pkg::REG_ADDR_W-1:0]];
				else
					bus = '0;
			end
			// Bus sits at zero when nobody drives it
			default: bus = '0;
		endcase
	end

endmodule

//--- source/alu.sv
module alu (
	input cpu_isa_pkg::opcode_t op,
	input cpu_isa_pkg::word_t a,
	input cpu_isa_pkg::word_t b,
	output cpu_isa_pkg::word_t y
);

	logic [4:0] sh;
	logic [2*cpu_isa_pkg::WORD_W-1:0] doubled;
	logic [2*cpu_isa_pkg::WORD_W-1:0] rot_r;
	logic [2*cpu_isa_pkg::WORD_W-1:0] rot_l;

	// Shift amount is the low 5 bits of the bus operand
	assign sh = b[4:0];

	// Rotates as shifts of the word placed next to itself
	assign doubled = {a, a};
	assign rot_r = doubled >> sh;
	assign rot_l = doubled << sh;

	always_comb begin
		case (op)
			cpu_isa_pkg::op_add: y = a + b;
			cpu_isa_pkg::op_sub: y = a - b;
			cpu_isa_pkg::op_shr: y = a >> sh;
			// Arithmetic shift keeps the sign
			cpu_isa_pkg::op_shra: y = $signed(a) >>> sh;
			cpu_isa_pkg::op_shl: y = a << sh;
			cpu_isa_pkg::op_ror: y = rot_r[cpu_isa_pkg::WORD_W-1:0];
			cpu_isa_pkg::op_rol: y = rot_l[2*cpu_isa_pkg::WORD_W-1:cpu_isa_pkg::WORD_W];
			cpu_isa_pkg::op_and: y = a & b;
			cpu_isa_pkg::op_or: y = a | b;
			// Unary ops only look at the bus side
			cpu_isa_pkg::op_neg: y = -b;
			cpu_isa_pkg::op_not: y = ~b;
			default: y = '0;
		endcase
	end

endmodule

//--- source/control_sequencer.sv
module control_sequencer (
	input logic clk,
	input logic arst_n,
	input logic req,
	input datapath_ctrl_pkg::cmd_t cmd,
	output logic ack,
	input cpu_isa_pkg::instr_t ir,
	output datapath_ctrl_pkg::ctrl_t ctrl
);

	datapath_ctrl_pkg::step_t step;
	datapath_ctrl_pkg::cmd_kind_t kind_q;
	cpu_isa_pkg::reg_idx_t target_q;
	logic accept;

	// New command only when idle and the previous ack has been dropped
	assign accept = (step == datapath_ctrl_pkg::st_idle) && req && !ack;

	always_ff @(posedge clk) begin
		if (accept) begin
			kind_q <= cmd.kind;
			target_q <= cmd.target;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step <= datapath_ctrl_pkg::st_idle;
			ack <= 1'b0;
		end else begin
			case (step)
				datapath_ctrl_pkg::st_idle:
					if (accept)
						step <= datapath_ctrl_pkg::st_mdr_in;
				datapath_ctrl_pkg::st_mdr_in:
					case (kind_q)
						datapath_ctrl_pkg::cmd_load: step <= datapath_ctrl_pkg::st_reg_in;
						datapath_ctrl_pkg::cmd_read: step <= datapath_ctrl_pkg::st_mdr_out;
						default: step <= datapath_ctrl_pkg::st_ir_in;
					endcase
				datapath_ctrl_pkg::st_reg_in: step <= datapath_ctrl_pkg::st_done;
				datapath_ctrl_pkg::st_ir_in: step <= datapath_ctrl_pkg::st_y_in;
				datapath_ctrl_pkg::st_y_in: step <= datapath_ctrl_pkg::st_z_in;
				datapath_ctrl_pkg::st_z_in: step <= datapath_ctrl_pkg::st_wb;
				datapath_ctrl_pkg::st_wb: step <= datapath_ctrl_pkg::st_done;
				datapath_ctrl_pkg::st_mdr_out: step <= datapath_ctrl_pkg::st_done;
				datapath_ctrl_pkg::st_done:
					// Hold ack until the requester lets go of req
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack <= 1'b0;
						step <= datapath_ctrl_pkg::st_idle;
					end
				default: step <= datapath_ctrl_pkg::st_idle;
			endcase
		end
	end

	// Control word per step
	always_comb begin
		ctrl = '0;
		ctrl.bus_src = datapath_ctrl_pkg::src_none;
		case (step)
			datapath_ctrl_pkg::st_mdr_in: begin
				ctrl.mdr_load = 1'b1;
				// A read takes the target register off the bus
				if (kind_q == datapath_ctrl_pkg::cmd_read) begin
					ctrl.mdr_from_bus = 1'b1;
					ctrl.bus_src = datapath_ctrl_pkg::src_gpr;
					ctrl.bus_reg = target_q;
				end
			end
			datapath_ctrl_pkg::st_reg_in: begin
				ctrl.bus_src = datapath_ctrl_pkg::src_mdr;
				ctrl.gpr_load = 1'b1;
				ctrl.gpr_sel = target_q;
			end
			datapath_ctrl_pkg::st_ir_in: begin
				ctrl.bus_src = datapath_ctrl_pkg::src_mdr;
				ctrl.ir_load = 1'b1;
			end
			datapath_ctrl_pkg::st_y_in: begin
				ctrl.bus_src = datapath_ctrl_pkg::src_gpr;
				ctrl.bus_reg = ir.rb;
				ctrl.y_load = 1'b1;
			end
			datapath_ctrl_pkg::st_z_in: begin
				ctrl.bus_src = datapath_ctrl_pkg::src_gpr;
				ctrl.bus_reg = ir.rc;
				ctrl.z_load = 1'b1;
			end
			datapath_ctrl_pkg::st_wb: begin
				ctrl.bus_src = datapath_ctrl_pkg::src_z;
				ctrl.gpr_load = 1'b1;
				ctrl.gpr_sel = ir.ra;
			end
			datapath_ctrl_pkg::st_mdr_out: ctrl.bus_src = datapath_ctrl_pkg::src_mdr;
			default: ;
		endcase
	end

endmodule

//--- source/datapath_top.sv
module datapath_top (
	input logic clk,
	input logic arst_n,
	input logic req,
	input datapath_ctrl_pkg::cmd_t cmd,
	output logic ack,
	output cpu_isa_pkg::word_t rdata
);

	datapath_ctrl_pkg::ctrl_t ctrl;
	cpu_isa_pkg::instr_t ir_q;
	cpu_isa_pkg::word_t bus;
	cpu_isa_pkg::word_t alu_y;
	cpu_isa_pkg::word_t y_q;
	cpu_isa_pkg::word_t z_q;
	cpu_isa_pkg::word_t mdr_d;
	cpu_isa_pkg::word_t mdr_q;
	cpu_isa_pkg::word_t gpr_q [cpu_isa_pkg::NUM_REGS];

	control_sequencer control_sequencer_i (
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.cmd(cmd),
		.ack(ack),
		.ir(ir_q),
		.ctrl(ctrl)
	);

	// MDR takes either the command data or the bus
	assign mdr_d = ctrl.mdr_from_bus ? bus : cmd.data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mdr_q <= '0;
		end else if (ctrl.mdr_load) begin
			mdr_q <= mdr_d;
		end
	end

	assign rdata = mdr_q;

	// R0-R7, one write enable decoded from gpr_sel
	for (genvar i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin : g_gpr
		gp_register #(.payload_t(cpu_isa_pkg::word_t)) gpr_i (
			.clk(clk),
			.arst_n(arst_n),
			.load(ctrl.gpr_load && (ctrl.gpr_sel == cpu_isa_pkg::reg_idx_t'(i))),
			.d(bus),
			.q(gpr_q[i])
		);
	end

	// IR keeps the decoded instruction
	gp_register #(.payload_t(cpu_isa_pkg::instr_t)) ir_i (
		.clk(clk), .arst_n(arst_n), .load(ctrl.ir_load),
		.d(cpu_isa_pkg::instr_t'(bus)), .q(ir_q)
	);

	gp_register #(.payload_t(cpu_isa_pkg::word_t)) y_i (
		.clk(clk), .arst_n(arst_n), .load(ctrl.y_load), .d(bus), .q(y_q)
	);

	gp_register #(.payload_t(cpu_isa_pkg::word_t)) z_i (
		.clk(clk), .arst_n(arst_n), .load(ctrl.z_load), .d(alu_y), .q(z_q)
	);

	bus_mux bus_mux_i (
		.bus_src(ctrl.bus_src),
		.bus_reg(ctrl.bus_reg),
		.mdr(mdr_q),
		.z(z_q),
		.gpr(gpr_q),
		.bus(bus)
	);

	alu alu_i (
		.op(ir_q.opcode),
		.a(y_q),
		.b(bus),
		.y(alu_y)
	);

endmodule

//--- test/datapath_chk.sv
module datapath_chk (
	input logic clk,
	input logic arst_n,
	input logic req,
	input logic ack,
	input datapath_ctrl_pkg::ctrl_t ctrl,
	input datapath_ctrl_pkg::step_t step
);

	timeunit 1ns;
	timeprecision 100ps;

	// No ack without a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		(!ack && !req) |=> !ack)
		else $error("ack rose with req low");

	// ack held as long as req is held
	ack_holds_with_req: assert property (@(posedge clk) disable iff (!arst_n)
		(ack && req) |=> ack)
		else $error("ack fell while req was still high");

	// Only one register write source per cycle
	one_writer: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({ctrl.gpr_load, ctrl.ir_load, ctrl.z_load}))
		else $error("more than one of gpr_load, ir_load, z_load active");

	quiet_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(step == datapath_ctrl_pkg::st_idle) |->
		!(ctrl.mdr_load || ctrl.gpr_load || ctrl.ir_load || ctrl.y_load || ctrl.z_load))
		else $error("enable active in idle");

endmodule

bind control_sequencer datapath_chk datapath_chk_i (
	.clk(clk),
	.arst_n(arst_n),
	.req(req),
	.ack(ack),
	.ctrl(ctrl),
	.step(step)
);

//--- test/datapath_tb.sv
module datapath_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;
	localparam int CYCLES_PER_CMD = 20;
	localparam int N_OPS = 11;
	localparam int N_EXEC = 44;
	localparam int N_AMTS = 4;
	localparam int N_SHIFT_OPS = 4;
	localparam int HOLD_CYCLES = 6;
	localparam int NREG = cpu_isa_pkg::NUM_REGS;

	// Commands per test: readback, random ops, shift corners, aliasing, held req
	localparam int TOTAL_CMDS = 2 * NREG + 2 * N_EXEC + 5 + N_AMTS * (1 + 2 * N_SHIFT_OPS)
		+ 9 + 2 + NREG;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + CYCLES_PER_CMD * TOTAL_CMDS;

	logic clk;
	logic arst_n;
	logic req;
	logic ack;
	datapath_ctrl_pkg::cmd_t cmd;
	cpu_isa_pkg::word_t rdata;

	cpu_isa_pkg::word_t shadow [NREG];
	cpu_isa_pkg::word_t exp_q [$];
	int issued;
	logic ack_seen;

	cpu_isa_pkg::opcode_t op_list [N_OPS] = '{
		cpu_isa_pkg::op_add, cpu_isa_pkg::op_sub, cpu_isa_pkg::op_shr,
		cpu_isa_pkg::op_shra, cpu_isa_pkg::op_shl, cpu_isa_pkg::op_ror,
		cpu_isa_pkg::op_rol, cpu_isa_pkg::op_and, cpu_isa_pkg::op_or,
		cpu_isa_pkg::op_neg, cpu_isa_pkg::op_not
	};
	cpu_isa_pkg::opcode_t shift_ops [N_SHIFT_OPS] = '{
		cpu_isa_pkg::op_shr, cpu_isa_pkg::op_shl, cpu_isa_pkg::op_ror, cpu_isa_pkg::op_rol
	};
	int shift_amts [N_AMTS] = '{0, 31, 32, 45};

	datapath_top datapath_top_i (
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.cmd(cmd),
		.ack(ack),
		.rdata(rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Expected Ra value from operands Rb (a) and Rc (b)
	function automatic cpu_isa_pkg::word_t expected_result(
		input cpu_isa_pkg::instr_t ins,
		input cpu_isa_pkg::word_t regs [NREG]
	);
		cpu_isa_pkg::word_t a;
		cpu_isa_pkg::word_t b;
		cpu_isa_pkg::word_t r;
		int amt;
		a = regs[int'(ins.rb)];
		b = regs[int'(ins.rc)];
		amt = int'(b[4:0]);
		r = a;
		case (ins.opcode)
			cpu_isa_pkg::op_add: r = a + b;
			cpu_isa_pkg::op_sub: r = a + ~b + 32'd1;
			cpu_isa_pkg::op_shr: r = a >> amt;
			cpu_isa_pkg::op_shra:
				for (int k = 0; k < amt; k++)
					r = {r[31], r[31:1]};
			cpu_isa_pkg::op_shl: r = a << amt;
			cpu_isa_pkg::op_ror:
				for (int k = 0; k < amt; k++)
					r = {r[0], r[31:1]};
			cpu_isa_pkg::op_rol:
				for (int k = 0; k < amt; k++)
					r = {r[30:0], r[31]};
			cpu_isa_pkg::op_and: r = a & b;
			cpu_isa_pkg::op_or: r = a | b;
			cpu_isa_pkg::op_neg: r = ~b + 32'd1;
			cpu_isa_pkg::op_not: r = ~b;
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic cpu_isa_pkg::instr_t make_instr(
		input cpu_isa_pkg::opcode_t op, input int ra, input int rb, input int rc
	);
		cpu_isa_pkg::instr_t ins;
		ins = '0;
		ins.opcode = op;
		ins.ra = cpu_isa_pkg::reg_idx_t'(ra);
		ins.rb = cpu_isa_pkg::reg_idx_t'(rb);
		ins.rc = cpu_isa_pkg::reg_idx_t'(rc);
		return ins;
	endfunction

	task automatic check_word(input cpu_isa_pkg::word_t expected, input cpu_isa_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Fail at %0t: rdata expected %h, got %h", $time, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic check_ack(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail at %0t: ack expected %b, got %b", $time, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "ack level mismatch");
		end
	endtask

	// Four-phase handshake, req kept high for hold extra cycles after ack
	task automatic run_cmd(input datapath_ctrl_pkg::cmd_kind_t kind,
		input cpu_isa_pkg::reg_idx_t target, input cpu_isa_pkg::word_t data, input int hold);
		@(negedge clk);
		cmd.kind = kind;
		cmd.target = target;
		cmd.data = data;
		req = 1'b1;
		issued++;
		do @(negedge clk); while (!ack);
		repeat (hold) begin
			@(negedge clk);
			check_ack(1'b1, ack);
		end
		req = 1'b0;
		do @(negedge clk); while (ack);
	endtask

	task automatic load_reg(input int r, input cpu_isa_pkg::word_t value);
		shadow[r] = value;
		run_cmd(datapath_ctrl_pkg::cmd_load, cpu_isa_pkg::reg_idx_t'(r), value, 0);
	endtask

	task automatic read_expect(input int r, input cpu_isa_pkg::word_t value);
		exp_q.push_back(value);
		run_cmd(datapath_ctrl_pkg::cmd_read, cpu_isa_pkg::reg_idx_t'(r), '0, 0);
	endtask

	task automatic read_reg(input int r);
		read_expect(r, shadow[r]);
	endtask

	task automatic exec_instr(input cpu_isa_pkg::instr_t ins, input int hold);
		cpu_isa_pkg::word_t result;
		result = expected_result(ins, shadow);
		shadow[int'(ins.ra)] = result;
		run_cmd(datapath_ctrl_pkg::cmd_execute, ins.ra, cpu_isa_pkg::word_t'(ins), hold);
	endtask

	// Compare rdata on the first cycle ack is seen high for a read
	always @(negedge clk) begin : compare_reads
		cpu_isa_pkg::word_t expected;
		if (arst_n && ack && !ack_seen && cmd.kind == datapath_ctrl_pkg::cmd_read) begin
			if (exp_q.size() == 0) begin
				$display("A read was acknowledged with no expected value queued");
				$display("RESULT: FAIL");
				$fatal(1, "unexpected read");
			end else begin
				expected = exp_q.pop_front();
				check_word(expected, rdata);
			end
		end
		ack_seen = ack;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin : stimulus
		cpu_isa_pkg::instr_t ins;
		int ra;
		int rb;
		int rc;
		void'($urandom(92545));
		arst_n = 1'b0;
		req = 1'b0;
		cmd = '0;
		issued = 0;
		ack_seen = 1'b0;
		for (int i = 0; i < NREG; i++)
			shadow[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Load and read back every register
		for (int i = 0; i < NREG; i++)
			load_reg(i, $urandom());
		for (int i = 0; i < NREG; i++)
			read_reg(i);

		// Random instructions across all opcodes
		for (int i = 0; i < N_EXEC; i++) begin
			ra = $urandom_range(NREG - 1);
			rb = $urandom_range(NREG - 1);
			rc = $urandom_range(NREG - 1);
			ins = make_instr(op_list[i % N_OPS], ra, rb, rc);
			exec_instr(ins, 0);
			read_reg(ra);
		end

		// Sign fill case, then shift corners on a pattern with both ends set
		load_reg(1, 32'hFFFF_FFF8);
		load_reg(2, 32'd1);
		exec_instr(make_instr(cpu_isa_pkg::op_shra, 3, 1, 2), 0);
		read_expect(3, 32'hFFFF_FFFC);
		load_reg(4, 32'h8000_00F1);
		for (int i = 0; i < N_AMTS; i++) begin
			load_reg(5, cpu_isa_pkg::word_t'(shift_amts[i]));
			for (int j = 0; j < N_SHIFT_OPS; j++) begin
				exec_instr(make_instr(shift_ops[j], 6, 4, 5), 0);
				read_reg(6);
			end
		end

		// Destination aliased with a source
		load_reg(1, $urandom());
		load_reg(2, $urandom());
		exec_instr(make_instr(cpu_isa_pkg::op_add, 1, 1, 2), 0);
		read_reg(1);
		exec_instr(make_instr(cpu_isa_pkg::op_sub, 2, 1, 2), 0);
		read_reg(2);
		load_reg(3, $urandom());
		exec_instr(make_instr(cpu_isa_pkg::op_rol, 3, 3, 3), 0);
		read_reg(3);

		// A repeated start would double R2 twice
		exec_instr(make_instr(cpu_isa_pkg::op_add, 2, 2, 2), HOLD_CYCLES);
		read_reg(2);
		for (int i = 0; i < NREG; i++)
			read_reg(i);

		@(negedge clk);
		if (exp_q.size() != 0 || issued != TOTAL_CMDS) begin
			$display("Run incomplete: %0d reads not compared, %0d of %0d commands issued",
				exp_q.size(), issued, TOTAL_CMDS);
			$display("RESULT: FAIL");
			$fatal(1, "incomplete run");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

//--- files.f
source/cpu_isa_pkg.sv
source/datapath_ctrl_pkg.sv
source/gp_register.sv
source/bus_mux.sv
source/alu.sv
source/control_sequencer.sv
source/datapath_top.sv
test/datapath_chk.sv
test/datapath_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= datapath_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
